/* filelist.f */
logic/npc_pkg.sv
logic/pc_hash.sv
logic/btb.sv
logic/ras.sv
logic/cpht.sv
logic/npc_predictor.sv
logic/npc_top.sv
sim/npc_tb.sv

/* sim/npc_tb.sv */
module npc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // reset plus tests 1 to 5 plus the random mix
    localparam int TEST_CYCLES    = 10 + 20 + 16 + 32 + 16 + 8 + 400;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;
    localparam int BTB_ENTRIES    = 2**npc_pkg::H_WIDTH;
    localparam int CPHT_ENTRIES   = 2**npc_pkg::K_WIDTH;
    localparam npc_pkg::addr_t RET_SITE = 30'h3000;

    logic              clk = 1'b0;
    logic              rst_n;
    npc_pkg::addr_t    pc;
    npc_pkg::kind_t    kind_pdc;
    logic              taken_pdc;
    npc_pkg::addr_t    npc_pdc;
    logic              choice_btb_ras;
    npc_pkg::chooser_t choice_pdch;
    npc_pkg::khash_t   pc_hashed;
    npc_pkg::hhash_t   pc_bh_hashed;
    logic              update_en;
    npc_pkg::kind_t    kind_ex;
    logic              taken_ex;
    npc_pkg::addr_t    pc_ex;
    npc_pkg::addr_t    npc_ex;
    npc_pkg::khash_t   pc_ex_hashed;
    npc_pkg::hhash_t   pc_ex_bh_hashed;
    npc_pkg::addr_t    ret_pc_ex;
    logic              choice_real;
    npc_pkg::chooser_t choice_pdch_ex;

    // reference model state
    npc_pkg::hhash_t   m_hist;
    logic              m_valid  [BTB_ENTRIES];
    npc_pkg::addr_t    m_tag    [BTB_ENTRIES];
    npc_pkg::addr_t    m_target [BTB_ENTRIES];
    npc_pkg::addr_t    m_stack  [npc_pkg::STACK_LEN];
    int                m_ptr;
    npc_pkg::chooser_t m_cpht   [CPHT_ENTRIES];

    string       test_name = "reset";
    int          cycle_count = 0;
    int unsigned seed;

    npc_top DUT (.*);

    always #2 clk = ~clk;

    function automatic npc_pkg::addr_t seq_next(input npc_pkg::addr_t p);
        return p[0] ? p + 30'd1 : p + 30'd2;
    endfunction

    function automatic npc_pkg::khash_t chooser_index(input npc_pkg::addr_t p);
        return p[5:0] ^ p[11:6];
    endfunction

    function automatic npc_pkg::hhash_t btb_index(input npc_pkg::addr_t p);
        return p[5:0] ^ m_hist;
    endfunction

    function automatic npc_pkg::chooser_t counter_step(input npc_pkg::chooser_t c,
                                                       input logic up);
        if (up) begin
            return (c == 2'd3) ? c : npc_pkg::chooser_t'(c + 2'd1);
        end
        return (c == 2'd0) ? c : npc_pkg::chooser_t'(c - 2'd1);
    endfunction

    // expected next pc from the model tables
    function automatic npc_pkg::addr_t expected_npc(input npc_pkg::addr_t p,
                                                    input npc_pkg::kind_t k, input logic t);
        npc_pkg::hhash_t idx;
        idx = btb_index(p);
        if (!t || k == npc_pkg::KIND_NOT_JUMP) begin
            return seq_next(p);
        end
        if (k == npc_pkg::KIND_RET) begin
            if (m_cpht[chooser_index(p)][1]) begin
                return m_target[idx];
            end
            return m_stack[(m_ptr + npc_pkg::STACK_LEN - 1) % npc_pkg::STACK_LEN];
        end
        if (k == npc_pkg::KIND_DIRECT || k == npc_pkg::KIND_INDIRECT ||
            k == npc_pkg::KIND_CALL || k == npc_pkg::KIND_JUMP) begin
            if (m_valid[idx] && m_tag[idx] == p) begin
                return m_target[idx];
            end
        end
        return seq_next(p);
    endfunction

    // kinds 2 and 3 are unused so 2..5 map onto 4..7
    function automatic npc_pkg::kind_t rand_kind();
        int r;
        r = $urandom_range(0, 5);
        return npc_pkg::kind_t'((r < 2) ? r : r + 2);
    endfunction

    function automatic npc_pkg::addr_t pool_pc();
        return npc_pkg::addr_t'(32'h400 + $urandom_range(0, 15));
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // consume the update the DUT samples at this edge
    task automatic apply_update();
        if (update_en) begin
            if (kind_ex != npc_pkg::KIND_NOT_JUMP) begin
                m_hist = {m_hist[npc_pkg::H_WIDTH-2:0], taken_ex};
                if (taken_ex) begin
                    m_valid[pc_ex_bh_hashed]  = 1'b1;
                    m_tag[pc_ex_bh_hashed]    = pc_ex;
                    m_target[pc_ex_bh_hashed] = npc_ex;
                end
            end
            if (kind_ex == npc_pkg::KIND_CALL) begin
                m_stack[m_ptr] = ret_pc_ex;
                m_ptr = (m_ptr + 1) % npc_pkg::STACK_LEN;
            end else if (kind_ex == npc_pkg::KIND_RET) begin
                m_ptr = (m_ptr + npc_pkg::STACK_LEN - 1) % npc_pkg::STACK_LEN;
                m_cpht[pc_ex_hashed] = counter_step(choice_pdch_ex, choice_real);
            end
        end
    endtask

    task automatic step(input npc_pkg::addr_t p, input npc_pkg::kind_t kp, input logic tp,
                        input logic ue, input npc_pkg::kind_t ke, input logic te,
                        input npc_pkg::addr_t pe, input npc_pkg::addr_t ne,
                        input npc_pkg::addr_t re, input logic cr);
        npc_pkg::khash_t kh;
        @(posedge clk);
        apply_update();
        kh = chooser_index(pe);
        pc              <= p;
        kind_pdc        <= kp;
        taken_pdc       <= tp;
        update_en       <= ue;
        kind_ex         <= ke;
        taken_ex        <= te;
        pc_ex           <= pe;
        npc_ex          <= ne;
        // hashes and counter as fetch would have carried them
        pc_ex_hashed    <= kh;
        pc_ex_bh_hashed <= btb_index(pe);
        ret_pc_ex       <= re;
        choice_real     <= cr;
        choice_pdch_ex  <= m_cpht[kh];
    endtask

    task automatic lookup(input npc_pkg::addr_t p, input npc_pkg::kind_t k, input logic t);
        step(p, k, t, 1'b0, npc_pkg::KIND_NOT_JUMP, 1'b0, '0, '0, '0, 1'b0);
    endtask

    task automatic update(input npc_pkg::kind_t k, input logic t, input npc_pkg::addr_t pe,
                          input npc_pkg::addr_t ne, input npc_pkg::addr_t re, input logic cr);
        step(pe, npc_pkg::KIND_NOT_JUMP, 1'b0, 1'b1, k, t, pe, ne, re, cr);
    endtask

    // outputs compared at the falling edge where inputs are stable
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("npc_pdc", expected_npc(pc, kind_pdc, taken_pdc), npc_pdc);
            check_value("pc_hashed", chooser_index(pc), pc_hashed);
            check_value("pc_bh_hashed", btb_index(pc), pc_bh_hashed);
            check_value("choice_pdch", m_cpht[chooser_index(pc)], choice_pdch);
            check_value("choice_btb_ras", m_cpht[chooser_index(pc)][1], choice_btb_ras);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        npc_pkg::addr_t p;
        npc_pkg::kind_t k;
        seed = 76651;
        seed = $urandom(seed);
        m_hist = '0;
        m_ptr  = 0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_target[i] = '0;
        end
        for (int i = 0; i < CPHT_ENTRIES; i++) begin
            m_cpht[i] = 2'd0;
        end
        for (int i = 0; i < npc_pkg::STACK_LEN; i++) begin
            m_stack[i] = '0;
        end
        rst_n <= 1'b0;
        pc <= '0;
        kind_pdc <= '0;
        taken_pdc <= 1'b0;
        update_en <= 1'b0;
        kind_ex <= '0;
        taken_ex <= 1'b0;
        pc_ex <= '0;
        npc_ex <= '0;
        pc_ex_hashed <= '0;
        pc_ex_bh_hashed <= '0;
        ret_pc_ex <= '0;
        choice_real <= 1'b0;
        choice_pdch_ex <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // odd and even pcs alternate on an empty btb
        test_name = "empty_btb";
        for (int i = 0; i < 20; i++) begin
            p = npc_pkg::addr_t'($urandom);
            p[0] = i[0];
            k = rand_kind();
            if (k == npc_pkg::KIND_RET) begin
                k = npc_pkg::KIND_DIRECT;
            end
            lookup(p, k, 1'($urandom_range(0, 1)));
            @(negedge clk);
            check_value("sequential npc", seq_next(p), npc_pdc);
        end

        // six taken jumps fill the history with ones
        test_name = "btb_train";
        for (int i = 0; i < 6; i++) begin
            update(npc_pkg::KIND_JUMP, 1'b1, 30'h200 + i * 4, 30'h300 + i, '0, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            k = (i == 0) ? npc_pkg::KIND_DIRECT
              : (i == 1) ? npc_pkg::KIND_JUMP : npc_pkg::KIND_INDIRECT;
            update(k, 1'b1, 30'h1040 + i * 2, 30'h20000 + i * 16, '0, 1'b0);
            lookup(30'h1040 + i * 2, k, 1'b1);
            @(negedge clk);
            check_value("trained target", 30'h20000 + i * 16, npc_pdc);
        end
        // same index as 0x1040 but another tag
        lookup(30'h1080, npc_pkg::KIND_DIRECT, 1'b1);
        @(negedge clk);
        check_value("aliased miss", 30'h1082, npc_pdc);

        test_name = "ras";
        for (int i = 0; i < 3; i++) begin
            update(npc_pkg::KIND_CALL, 1'b1, 30'h4000 + i * 2, 30'h5000, 30'h6000 + i, 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            step(RET_SITE, npc_pkg::KIND_RET, 1'b1, 1'b1, npc_pkg::KIND_RET, 1'b1,
                 RET_SITE, 30'h7000, '0, 1'b0);
            @(negedge clk);
            check_value("ras top", 30'h6002 - i, npc_pdc);
        end
        // ten calls into eight slots lose the two oldest
        for (int i = 0; i < 10; i++) begin
            update(npc_pkg::KIND_CALL, 1'b1, 30'h4100 + i * 2, 30'h5000, 30'h6100 + i, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            step(RET_SITE, npc_pkg::KIND_RET, 1'b1, 1'b1, npc_pkg::KIND_RET, 1'b1,
                 RET_SITE, 30'h7000, '0, 1'b0);
            @(negedge clk);
            check_value("wrapped ras top", 30'h6109 - i, npc_pdc);
        end

        test_name = "chooser";
        for (int i = 0; i < 4; i++) begin
            update(npc_pkg::KIND_RET, 1'b1, RET_SITE, 30'h7700, '0, 1'b1);
        end
        lookup(RET_SITE, npc_pkg::KIND_RET, 1'b1);
        @(negedge clk);
        check_value("btb return", 30'h7700, npc_pdc);
        check_value("saturated high", 2'd3, choice_pdch);
        for (int i = 0; i < 4; i++) begin
            update(npc_pkg::KIND_RET, 1'b1, RET_SITE, 30'h7700, '0, 1'b0);
        end
        lookup(RET_SITE, npc_pkg::KIND_RET, 1'b1);
        @(negedge clk);
        check_value("saturated low", 2'd0, choice_pdch);
        check_value("ras chosen", 1'b0, choice_btb_ras);
        // two returns predicted before either resolved carry the same counter
        update(npc_pkg::KIND_RET, 1'b1, RET_SITE, 30'h7700, '0, 1'b1);
        update(npc_pkg::KIND_RET, 1'b1, RET_SITE, 30'h7700, '0, 1'b1);
        choice_pdch_ex <= 2'd0;
        lookup(RET_SITE, npc_pkg::KIND_RET, 1'b1);
        @(negedge clk);
        check_value("stale carried counter", 2'd1, choice_pdch);

        // history is all ones and the pc low bits are 0x25
        test_name = "history";
        update(npc_pkg::KIND_NOT_JUMP, 1'b1, 30'h0a5, '0, '0, 1'b0);
        lookup(30'h0a5, npc_pkg::KIND_NOT_JUMP, 1'b0);
        @(negedge clk);
        check_value("not-jump keeps history", 6'h1a, pc_bh_hashed);
        update(npc_pkg::KIND_DIRECT, 1'b0, 30'h0a5, '0, '0, 1'b0);
        lookup(30'h0a5, npc_pkg::KIND_NOT_JUMP, 1'b0);
        @(negedge clk);
        check_value("not-taken shifts zero", 6'h1b, pc_bh_hashed);
        update(npc_pkg::KIND_JUMP, 1'b1, 30'h0a5, 30'h0b0, '0, 1'b0);
        lookup(30'h0a5, npc_pkg::KIND_NOT_JUMP, 1'b0);
        @(negedge clk);
        check_value("taken shifts one", 6'h18, pc_bh_hashed);

        test_name = "random_mix";
        for (int i = 0; i < 400; i++) begin
            step(pool_pc(), rand_kind(), 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)),
                 rand_kind(), 1'($urandom_range(0, 1)), pool_pc(),
                 npc_pkg::addr_t'($urandom), npc_pkg::addr_t'($urandom),
                 1'($urandom_range(0, 1)));
        end

        // let the last update land in the model and the DUT
        lookup('0, npc_pkg::KIND_NOT_JUMP, 1'b0);
        @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* logic/npc_top.sv */
module npc_top (
    input  logic              clk,
    input  logic              rst_n,
    // fetch
    input  npc_pkg::addr_t    pc,
    input  npc_pkg::kind_t    kind_pdc,
    input  logic              taken_pdc,
    output npc_pkg::addr_t    npc_pdc,
    output logic              choice_btb_ras,
    output npc_pkg::chooser_t choice_pdch,
    output npc_pkg::khash_t   pc_hashed,
    output npc_pkg::hhash_t   pc_bh_hashed,
    // execute
    input  logic              update_en,
    input  npc_pkg::kind_t    kind_ex,
    input  logic              taken_ex,
    input  npc_pkg::addr_t    pc_ex,
    input  npc_pkg::addr_t    npc_ex,
    input  npc_pkg::khash_t   pc_ex_hashed,
    input  npc_pkg::hhash_t   pc_ex_bh_hashed,
    input  npc_pkg::addr_t    ret_pc_ex,
    input  logic              choice_real,
    input  npc_pkg::chooser_t choice_pdch_ex
);

    pc_hash u_pc_hash (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .update_en    (update_en),
        .kind_ex      (kind_ex),
        .taken_ex     (taken_ex),
        .pc_hashed    (pc_hashed),
        .pc_bh_hashed (pc_bh_hashed)
    );

    // hashes also leave the top so fetch can carry them to execute
    npc_predictor u_npc_predictor (
        .clk             (clk),
        .rst_n           (rst_n),
        .pc              (pc),
        .pc_hashed       (pc_hashed),
        .pc_bh_hashed    (pc_bh_hashed),
        .kind_pdc        (kind_pdc),
        .taken_pdc       (taken_pdc),
        .npc_pdc         (npc_pdc),
        .choice_btb_ras  (choice_btb_ras),
        .choice_pdch     (choice_pdch),
        .update_en       (update_en),
        .kind_ex         (kind_ex),
        .taken_ex        (taken_ex),
        .pc_ex           (pc_ex),
        .npc_ex          (npc_ex),
        .pc_ex_hashed    (pc_ex_hashed),
        .pc_ex_bh_hashed (pc_ex_bh_hashed),
        .ret_pc_ex       (ret_pc_ex),
        .choice_real     (choice_real),
        .choice_pdch_ex  (choice_pdch_ex)
    );

endmodule

/* logic/npc_predictor.sv */
module npc_predictor (
    input  logic              clk,
    input  logic              rst_n,
    // fetch side
    input  npc_pkg::addr_t    pc,
    input  npc_pkg::khash_t   pc_hashed,
    input  npc_pkg::hhash_t   pc_bh_hashed,
    input  npc_pkg::kind_t    kind_pdc,
    input  logic              taken_pdc,
    output npc_pkg::addr_t    npc_pdc,
    output logic              choice_btb_ras,
    output npc_pkg::chooser_t choice_pdch,
    // execute side
    input  logic              update_en,
    input  npc_pkg::kind_t    kind_ex,
    input  logic              taken_ex,
    input  npc_pkg::addr_t    pc_ex,
    input  npc_pkg::addr_t    npc_ex,
    input  npc_pkg::khash_t   pc_ex_hashed,
    input  npc_pkg::hhash_t   pc_ex_bh_hashed,
    input  npc_pkg::addr_t    ret_pc_ex,
    input  logic              choice_real,
    input  npc_pkg::chooser_t choice_pdch_ex
);

    npc_pkg::addr_t npc_btb;
    npc_pkg::addr_t npc_ras;
    npc_pkg::addr_t seq_pc;
    logic           btb_hit;
    logic           btb_we;
    logic           is_call_ex;
    logic           is_ret_ex;

    // execute-side decode
    assign btb_we     = update_en && taken_ex && (kind_ex != npc_pkg::KIND_NOT_JUMP);
    assign is_call_ex = update_en && (kind_ex == npc_pkg::KIND_CALL);
    assign is_ret_ex  = update_en && (kind_ex == npc_pkg::KIND_RET);

    btb u_btb (
        .clk                 (clk),
        .rst_n               (rst_n),
        .hashed_gh_pc        (pc_bh_hashed),
        .pc                  (pc),
        .npc_btb             (npc_btb),
        .hit                 (btb_hit),
        .hashed_gh_pc_update (pc_ex_bh_hashed),
        .pc_update           (pc_ex),
        .npc_real            (npc_ex),
        .update_en           (btb_we)
    );

    ras u_ras (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (is_call_ex),
        .pop        (is_ret_ex),
        .ret_pc_ex  (ret_pc_ex),
        .ret_pc_pdc (npc_ras)
    );

    cpht u_cpht (
        .clk              (clk),
        .rst_n            (rst_n),
        .hashed_pc        (pc_hashed),
        .choice_pdch      (choice_pdch),
        .choice_pdc       (choice_btb_ras),
        .hashed_pc_update (pc_ex_hashed),
        .choice_real      (choice_real),
        .choice_pdch_ex   (choice_pdch_ex),
        .update_en        (is_ret_ex)
    );

    // odd pc steps by one, even pc by two
    assign seq_pc = pc[0] ? pc + 1'b1 : pc + 2'd2;

    always_comb begin
        npc_pdc = seq_pc;
        if (taken_pdc) begin
            case (kind_pdc)
                npc_pkg::KIND_RET: begin
                    npc_pdc = choice_btb_ras ? npc_btb : npc_ras;
                end
                npc_pkg::KIND_DIRECT,
                npc_pkg::KIND_INDIRECT,
                npc_pkg::KIND_CALL,
                npc_pkg::KIND_JUMP: begin
                    // fall through on a miss
                    npc_pdc = btb_hit ? npc_btb : seq_pc;
                end
                default: begin
                    npc_pdc = seq_pc;
                end
            endcase
        end
    end

endmodule

/* logic/cpht.sv */
module cpht (
    input  logic              clk,
    input  logic              rst_n,
    // predict side
    input  npc_pkg::khash_t   hashed_pc,
    output npc_pkg::chooser_t choice_pdch,
    output logic              choice_pdc,
    // update side
    input  npc_pkg::khash_t   hashed_pc_update,
    input  logic              choice_real,
    input  npc_pkg::chooser_t choice_pdch_ex,
    input  logic              update_en
);

    npc_pkg::chooser_t counters [2**npc_pkg::K_WIDTH];
    npc_pkg::chooser_t stepped;

    assign choice_pdch = counters[hashed_pc];

    // msb set means trust the btb, clear means the ras
    assign choice_pdc = choice_pdch[1];

    // step the value seen at predict time, not the current entry
    always_comb begin
        stepped = choice_pdch_ex;
        if (choice_real) begin
            if (choice_pdch_ex != 2'd3) begin
                stepped = choice_pdch_ex + 2'd1;
            end
        end else begin
            if (choice_pdch_ex != 2'd0) begin
                stepped = choice_pdch_ex - 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // start out trusting the ras
            for (int i = 0; i < 2**npc_pkg::K_WIDTH; i++) begin
                counters[i] <= 2'd0;
            end
        end else if (update_en) begin
            counters[hashed_pc_update] <= stepped;
        end
    end

endmodule

/* logic/ras.sv */
module ras (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  logic           pop,
    input  npc_pkg::addr_t ret_pc_ex,
    output npc_pkg::addr_t ret_pc_pdc
);

    typedef logic [$clog2(npc_pkg::STACK_LEN)-1:0] ptr_t;

    npc_pkg::addr_t stack [npc_pkg::STACK_LEN];

    // points at the next free slot
    ptr_t ptr;
    ptr_t ptr_inc;
    ptr_t ptr_dec;

    // wrap both ways, overflow drops the oldest return
    always_comb begin
        if (ptr == ptr_t'(npc_pkg::STACK_LEN - 1)) begin
            ptr_inc = '0;
        end else begin
            ptr_inc = ptr + 1'b1;
        end
        if (ptr == '0) begin
            ptr_dec = ptr_t'(npc_pkg::STACK_LEN - 1);
        end else begin
            ptr_dec = ptr - 1'b1;
        end
    end

    // top of stack sits just below the pointer
    assign ret_pc_pdc = stack[ptr_dec];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
            for (int i = 0; i < npc_pkg::STACK_LEN; i++) begin
                stack[i] <= '0;
            end
        end else if (push) begin
            stack[ptr] <= ret_pc_ex;
            ptr        <= ptr_inc;
        end else if (pop) begin
            ptr <= ptr_dec;
        end
    end

    // execute resolves one instruction per cycle, call and return exclusive
    a_no_push_pop: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(push && pop)
    ) else $error("ras push and pop in the same cycle");

endmodule

/* logic/btb.sv */
module btb (
    input  logic            clk,
    input  logic            rst_n,
    // predict side
    input  npc_pkg::hhash_t hashed_gh_pc,
    input  npc_pkg::addr_t  pc,
    output npc_pkg::addr_t  npc_btb,
    output logic            hit,
    // update side
    input  npc_pkg::hhash_t hashed_gh_pc_update,
    input  npc_pkg::addr_t  pc_update,
    input  npc_pkg::addr_t  npc_real,
    input  logic            update_en
);

    logic           entry_valid  [2**npc_pkg::H_WIDTH];
    npc_pkg::addr_t entry_tag    [2**npc_pkg::H_WIDTH];
    npc_pkg::addr_t entry_target [2**npc_pkg::H_WIDTH];

    // lookup is purely combinational
    assign npc_btb = entry_target[hashed_gh_pc];

    // full pc kept as tag so aliasing pcs miss
    assign hit = entry_valid[hashed_gh_pc] && (entry_tag[hashed_gh_pc] == pc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // all entries start empty
            for (int i = 0; i < 2**npc_pkg::H_WIDTH; i++) begin
                entry_valid[i]  <= 1'b0;
                entry_tag[i]    <= '0;
                entry_target[i] <= '0;
            end
        end else if (update_en) begin
            entry_valid[hashed_gh_pc_update]  <= 1'b1;
            entry_tag[hashed_gh_pc_update]    <= pc_update;
            entry_target[hashed_gh_pc_update] <= npc_real;
        end
    end

    // index travels down the cpu pipeline and must arrive intact
    a_update_index_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        update_en |-> !$isunknown(hashed_gh_pc_update)
    ) else $error("btb write with unknown index");

endmodule

/* logic/pc_hash.sv */
module pc_hash (
    input  logic            clk,
    input  logic            rst_n,
    input  npc_pkg::addr_t  pc,
    input  logic            update_en,
    input  npc_pkg::kind_t  kind_ex,
    input  logic            taken_ex,
    output npc_pkg::khash_t pc_hashed,
    output npc_pkg::hhash_t pc_bh_hashed
);

    npc_pkg::hhash_t global_hist;
    logic            hist_shift;

    // fold two slices of the pc for the chooser index
    assign pc_hashed = pc[npc_pkg::K_WIDTH-1:0]
                     ^ pc[2*npc_pkg::K_WIDTH-1:npc_pkg::K_WIDTH];

    // btb index mixes in the branch history
    assign pc_bh_hashed = pc[npc_pkg::H_WIDTH-1:0] ^ global_hist;

    // only resolved control flow moves the history
    assign hist_shift = update_en && (kind_ex != npc_pkg::KIND_NOT_JUMP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            global_hist <= '0;
        end else if (hist_shift) begin
            // newest outcome enters at bit 0
            global_hist <= {global_hist[npc_pkg::H_WIDTH-2:0], taken_ex};
        end
    end

endmodule

/* logic/npc_pkg.sv */
package npc_pkg;

    // word address width, same as the fetch pc
    localparam int ADDR_WIDTH = 30;

    // plain pc hash width, indexes the chooser
    localparam int K_WIDTH = 6;

    // history-hashed index width, also the global history length
    localparam int H_WIDTH = 6;

    // return address stack depth
    localparam int STACK_LEN = 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [K_WIDTH-1:0]    khash_t;
    typedef logic [H_WIDTH-1:0]    hhash_t;
    typedef logic [2:0]            kind_t;
    typedef logic [1:0]            chooser_t;

    // instruction kinds as decoded by the front end
    localparam kind_t KIND_NOT_JUMP = 3'd0;
    localparam kind_t KIND_DIRECT   = 3'd1;
    localparam kind_t KIND_RET      = 3'd4;
    localparam kind_t KIND_INDIRECT = 3'd5;
    localparam kind_t KIND_CALL     = 3'd6;
    localparam kind_t KIND_JUMP     = 3'd7;

endpackage
